/* common/ppu_bus_pkg.sv */
`default_nettype none

package ppu_bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;

    // CPU-visible regions
    localparam addr_t VRAM_BASE = 16'h8000;
    localparam addr_t VRAM_SIZE = 16'h2000;
    localparam addr_t IO_START  = 16'hff40;
    localparam addr_t IO_END    = 16'hff4b;

    localparam addr_t REG_LCDC = 16'hff40;
    localparam addr_t REG_STAT = 16'hff41;
    localparam addr_t REG_SCY  = 16'hff42;
    localparam addr_t REG_SCX  = 16'hff43;
    localparam addr_t REG_LY   = 16'hff44;   // Any write clears the line counter
    localparam addr_t REG_LYC  = 16'hff45;
    localparam addr_t REG_BGP  = 16'hff47;

    // LCDC bit layout, bit 7 first
    typedef struct packed {
        logic display_en;
        logic win_map;        // Read back only
        logic win_en;         // Read back only
        logic tile_data_sel;  // 1 selects the 8000 block
        logic bg_map;
        logic obj_size;       // Read back only
        logic obj_en;         // Read back only
        logic bg_en;
    } lcdc_t;

    // Configuration seen by the render path
    typedef struct packed {
        lcdc_t lcdc;
        byte_t scx;
        byte_t scy;
        byte_t bgp;
    } ppu_cfg_t;

endpackage

`default_nettype wire

/* common/ppu_video_pkg.sv */
`default_nettype none

package ppu_video_pkg;

    typedef logic [7:0] pos_t;
    typedef logic [8:0] dot_t;

    // STAT mode encoding
    typedef enum logic [1:0] {
        HBLANK = 2'b00,
        VBLANK = 2'b01,
        SEARCH = 2'b10,
        DRAW   = 2'b11
    } ppu_mode_e;

    typedef enum logic [3:0] {
        STOPPED,
        START,
        WAIT_MAP,
        READ_MAP,
        WAIT_LO,
        READ_LO,
        WAIT_HI,
        READ_HI,
        HOLD
    } fetch_state_e;

    // One row of a tile, leftmost pixel in bit 7
    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
    } tile_row_t;

    typedef struct packed {
        pos_t ly;
        logic line_start;  // Pulse at the end of the search period
        logic in_vblank;
    } line_info_t;

    localparam logic [15:0] MAP_BASE_0 = 16'h9800;
    localparam logic [15:0] MAP_BASE_1 = 16'h9c00;

    localparam logic [15:0] DATA_BASE_UNSIGNED = 16'h8000;
    localparam logic [15:0] DATA_BASE_SIGNED   = 16'h9000;  // Index 0 sits mid-block

endpackage

`default_nettype wire

/* verilog/ppu_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module ppu_regs (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire ppu_bus_pkg::addr_t       mem_addr,
    input  wire ppu_bus_pkg::byte_t       mem_data_write,
    input  wire logic                     mem_do_write,
    output ppu_bus_pkg::byte_t            mem_data_read,
    output logic                          mem_data_active,
    output ppu_bus_pkg::addr_t            vram_addr,
    output ppu_bus_pkg::byte_t            vram_data_w,
    input  wire ppu_bus_pkg::byte_t       vram_data_r,
    output logic                          vram_do_write,
    input  wire ppu_bus_pkg::addr_t       fetch_addr,
    input  wire logic                     fetch_busy,
    input  wire ppu_video_pkg::pos_t      ly,
    input  wire ppu_video_pkg::ppu_mode_e mode,
    output ppu_bus_pkg::ppu_cfg_t         cfg,
    output logic                          ly_reset
);
    import ppu_bus_pkg::*;

    byte_t      lyc;
    logic [3:0] stat_ie;      // LYC, OAM, vblank and hblank enables
    logic       in_vram;
    logic       in_io;
    logic       coincidence;

    assign in_vram = mem_addr >= VRAM_BASE && mem_addr < VRAM_BASE + VRAM_SIZE;
    assign in_io = mem_addr >= IO_START && mem_addr <= IO_END;
    assign coincidence = ly == lyc;

    assign mem_data_active = !mem_do_write && (in_vram || in_io);
    assign ly_reset = mem_do_write && mem_addr == REG_LY;

    // Fetcher owns the VRAM port while busy, CPU writes are dropped
    assign vram_addr = fetch_busy ? fetch_addr : mem_addr;
    assign vram_data_w = fetch_busy ? 8'h00 : mem_data_write;
    assign vram_do_write = !fetch_busy && mem_do_write && in_vram;

    always_comb begin
        mem_data_read = 8'hff;
        if (in_vram) begin
            if (!fetch_busy)
                mem_data_read = vram_data_r;
        end else if (in_io) begin
            case (mem_addr)
                REG_LCDC: mem_data_read = cfg.lcdc;
                REG_STAT: mem_data_read = {1'b0, stat_ie, coincidence, mode};
                REG_SCY:  mem_data_read = cfg.scy;
                REG_SCX:  mem_data_read = cfg.scx;
                REG_LY:   mem_data_read = ly;
                REG_LYC:  mem_data_read = lyc;
                REG_BGP:  mem_data_read = cfg.bgp;
                default:  mem_data_read = 8'hff;   // Unmapped IO
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
            lyc <= '0;
            stat_ie <= '0;
        end else if (mem_do_write && in_io) begin
            case (mem_addr)
                REG_LCDC: cfg.lcdc <= mem_data_write;
                REG_STAT: stat_ie <= mem_data_write[6:3];  // Low bits are status
                REG_SCY:  cfg.scy <= mem_data_write;
                REG_SCX:  cfg.scx <= mem_data_write;
                REG_LYC:  lyc <= mem_data_write;
                REG_BGP:  cfg.bgp <= mem_data_write;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ppu_timing.sv */
`default_nettype none
`timescale 1ns/1ns

module ppu_timing #(
    parameter int VISIBLE_H   = 144,
    parameter int LINE_DOTS   = 456,
    parameter int FRAME_LINES = 154,
    parameter int SEARCH_DOTS = 80
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                display_en,
    input  wire logic                ly_reset,
    input  wire logic                drawing,
    output ppu_video_pkg::line_info_t line,
    output ppu_video_pkg::ppu_mode_e  mode,
    output logic                     intreq_vblank
);
    import ppu_video_pkg::*;

    dot_t dot;
    pos_t ly;
    pos_t ly_prev;
    logic line_end;
    logic in_vblank;
    logic line_start;

    assign line_end = dot == dot_t'(LINE_DOTS - 1);
    assign in_vblank = ly >= pos_t'(VISIBLE_H);
    assign line_start = display_en && !in_vblank && dot == dot_t'(SEARCH_DOTS);

    assign line = '{ly: ly, line_start: line_start, in_vblank: in_vblank};

    // Counters freeze while the display is off
    always_ff @(posedge clk) begin
        if (reset) begin
            dot <= '0;
            ly <= '0;
        end else begin
            if (display_en)
                dot <= line_end ? '0 : dot + 1'b1;
            if (ly_reset)
                ly <= '0;
            else if (display_en && line_end)
                ly <= (ly == pos_t'(FRAME_LINES - 1)) ? '0 : ly + 1'b1;
        end
    end

    // Request lands one cycle after LY enters vblank
    always_ff @(posedge clk) begin
        if (reset) begin
            ly_prev <= '0;
            intreq_vblank <= 1'b0;
        end else begin
            ly_prev <= ly;
            intreq_vblank <= ly == pos_t'(VISIBLE_H) && ly_prev != pos_t'(VISIBLE_H);
        end
    end

    always_comb begin
        if (in_vblank)
            mode = VBLANK;
        else if (dot < dot_t'(SEARCH_DOTS))
            mode = SEARCH;
        else if (drawing || line_start)
            mode = DRAW;
        else
            mode = HBLANK;
    end

endmodule

`default_nettype wire

/* render/bg_fetcher.sv */
`default_nettype none
`timescale 1ns/1ns

module bg_fetcher (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire ppu_bus_pkg::ppu_cfg_t    cfg,
    input  wire ppu_video_pkg::line_info_t line,
    input  wire logic                     line_abort,
    input  wire logic                     row_taken,
    input  wire ppu_bus_pkg::byte_t       vram_data_r,
    output ppu_bus_pkg::addr_t            fetch_addr,
    output logic                          fetch_busy,
    output ppu_video_pkg::tile_row_t      row,
    output logic                          row_valid
);
    import ppu_bus_pkg::*;
    import ppu_video_pkg::*;

    fetch_state_e state;
    logic [4:0]   tile_x;    // Map column, wraps at 32
    byte_t        tile_idx;
    byte_t        bg_y;
    addr_t        map_base;
    addr_t        map_addr;

    // Byte address of one plane of a tile row
    function automatic addr_t tile_addr(input logic data_sel, input byte_t idx,
                                        input logic [2:0] fine, input logic plane);
        addr_t offset;
        offset = {{4{idx[7] & ~data_sel}}, idx, fine, plane};
        return (data_sel ? DATA_BASE_UNSIGNED : DATA_BASE_SIGNED) + offset;
    endfunction

    assign bg_y = line.ly + cfg.scy;
    assign map_base = cfg.lcdc.bg_map ? MAP_BASE_1 : MAP_BASE_0;
    assign map_addr = map_base + {6'b0, bg_y[7:3], tile_x};
    assign fetch_busy = state != STOPPED;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STOPPED;
            row_valid <= 1'b0;
        end else if (line_abort || !cfg.lcdc.display_en) begin
            state <= STOPPED;
            row_valid <= 1'b0;
        end else begin
            case (state)
                STOPPED:  if (line.line_start) state <= START;
                START:    state <= WAIT_MAP;
                WAIT_MAP: state <= READ_MAP;
                READ_MAP: state <= WAIT_LO;
                WAIT_LO:  state <= READ_LO;
                READ_LO:  state <= WAIT_HI;
                WAIT_HI:  state <= READ_HI;
                READ_HI: begin
                    state <= HOLD;
                    row_valid <= 1'b1;
                end
                HOLD: begin
                    if (row_taken) begin
                        state <= WAIT_MAP;   // Next map address is already out
                        row_valid <= 1'b0;
                    end
                end
                default: state <= STOPPED;
            endcase
        end
    end

    // Address goes out one cycle before its data comes back
    always_ff @(posedge clk) begin
        case (state)
            STOPPED: tile_x <= cfg.scx[7:3];
            START:   fetch_addr <= map_addr;
            READ_MAP: begin
                tile_idx <= vram_data_r;
                fetch_addr <= tile_addr(cfg.lcdc.tile_data_sel, vram_data_r, bg_y[2:0], 1'b0);
            end
            READ_LO: begin
                row.lo <= vram_data_r;
                fetch_addr <= tile_addr(cfg.lcdc.tile_data_sel, tile_idx, bg_y[2:0], 1'b1);
            end
            READ_HI: begin
                row.hi <= vram_data_r;
                tile_x <= tile_x + 1'b1;
            end
            HOLD:    fetch_addr <= map_addr;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* render/pixel_fifo.sv */
`default_nettype none
`timescale 1ns/1ns

module pixel_fifo #(
    parameter int VISIBLE_W = 160
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire ppu_bus_pkg::ppu_cfg_t     cfg,
    input  wire ppu_video_pkg::line_info_t line,
    input  wire ppu_video_pkg::tile_row_t  row,
    input  wire logic                      row_valid,
    output logic                           row_taken,
    output logic                           line_abort,
    output logic                           drawing,
    output logic                           lcd_write,
    output logic [1:0]                     lcd_col,
    output ppu_video_pkg::pos_t            lcd_x,
    output ppu_video_pkg::pos_t            lcd_y,
    output logic                           lcd_hblank,
    output logic                           lcd_vblank
);
    import ppu_video_pkg::*;

    logic [15:0] sh_lo;    // Next pixel in bit 15
    logic [15:0] sh_hi;
    logic [4:0]  count;    // Queued pixels, 0 to 16
    logic [2:0]  discard;  // Fine scroll pixels still to drop
    pos_t        x;
    logic        line_done;
    logic        shift;
    logic [1:0]  pix;

    assign line_done = x == pos_t'(VISIBLE_W);
    assign row_taken = drawing && !line_done && row_valid && count <= 5'd8;
    assign shift = drawing && !line_done && count > 5'd8;  // Stall below nine
    assign pix = {sh_hi[15], sh_lo[15]};

    always_ff @(posedge clk) begin
        if (reset) begin
            drawing <= 1'b0;
            count <= '0;
            discard <= '0;
            x <= '0;
            line_abort <= 1'b0;
            lcd_write <= 1'b0;
            lcd_hblank <= 1'b0;
            lcd_vblank <= 1'b0;
        end else begin
            line_abort <= 1'b0;
            lcd_write <= 1'b0;
            lcd_hblank <= 1'b0;
            lcd_vblank <= line.in_vblank;
            if (!cfg.lcdc.display_en) begin
                drawing <= 1'b0;
            end else if (line.line_start) begin
                drawing <= 1'b1;
                count <= '0;
                discard <= cfg.scx[2:0];
                x <= '0;
            end else if (drawing && line_done) begin
                drawing <= 1'b0;
                line_abort <= 1'b1;
                lcd_hblank <= 1'b1;
            end else if (row_taken) begin
                count <= count + 5'd8;
            end else if (shift) begin
                count <= count - 5'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;
                end else begin
                    lcd_write <= 1'b1;
                    x <= x + 1'b1;
                end
            end
        end
    end

    // New row lands right behind the pixels still queued
    always_ff @(posedge clk) begin
        if (line.line_start) begin
            sh_lo <= '0;
            sh_hi <= '0;
        end else if (row_taken) begin
            sh_lo <= sh_lo | ({row.lo, 8'h00} >> count);
            sh_hi <= sh_hi | ({row.hi, 8'h00} >> count);
        end else if (shift) begin
            sh_lo <= {sh_lo[14:0], 1'b0};
            sh_hi <= {sh_hi[14:0], 1'b0};
            lcd_col <= cfg.lcdc.bg_en ? cfg.bgp[{pix, 1'b0} +: 2] : 2'b00;
            lcd_x <= x;
            lcd_y <= line.ly;
        end
    end

endmodule

`default_nettype wire

/* verilog/ppu_top.sv */
`default_nettype none
`timescale 1ns/1ns

module ppu_top #(
    parameter int VISIBLE_W   = 160,
    parameter int VISIBLE_H   = 144,
    parameter int LINE_DOTS   = 456,
    parameter int FRAME_LINES = 154,
    parameter int SEARCH_DOTS = 80
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ppu_bus_pkg::addr_t   mem_addr,
    input  wire ppu_bus_pkg::byte_t   mem_data_write,
    input  wire logic                 mem_do_write,
    output ppu_bus_pkg::byte_t        mem_data_read,
    output logic                      mem_data_active,
    output ppu_bus_pkg::addr_t        vram_addr,
    output ppu_bus_pkg::byte_t        vram_data_w,
    input  wire ppu_bus_pkg::byte_t   vram_data_r,
    output logic                      vram_do_write,
    output logic                      intreq_vblank,
    output logic                      lcd_hblank,
    output logic                      lcd_vblank,
    output logic                      lcd_write,
    output logic [1:0]                lcd_col,
    output ppu_video_pkg::pos_t       lcd_x,
    output ppu_video_pkg::pos_t       lcd_y
);
    import ppu_bus_pkg::*;
    import ppu_video_pkg::*;

    ppu_cfg_t   cfg;
    line_info_t line;
    ppu_mode_e  mode;
    tile_row_t  row;
    addr_t      fetch_addr;
    logic       fetch_busy;
    logic       ly_reset;
    logic       drawing;
    logic       row_valid;
    logic       row_taken;
    logic       line_abort;

    ppu_regs i_ppu_regs (
        .clk             (clk),
        .reset           (reset),
        .mem_addr        (mem_addr),
        .mem_data_write  (mem_data_write),
        .mem_do_write    (mem_do_write),
        .mem_data_read   (mem_data_read),
        .mem_data_active (mem_data_active),
        .vram_addr       (vram_addr),
        .vram_data_w     (vram_data_w),
        .vram_data_r     (vram_data_r),
        .vram_do_write   (vram_do_write),
        .fetch_addr      (fetch_addr),
        .fetch_busy      (fetch_busy),
        .ly              (line.ly),
        .mode            (mode),
        .cfg             (cfg),
        .ly_reset        (ly_reset)
    );

    ppu_timing #(
        .VISIBLE_H   (VISIBLE_H),
        .LINE_DOTS   (LINE_DOTS),
        .FRAME_LINES (FRAME_LINES),
        .SEARCH_DOTS (SEARCH_DOTS)
    ) i_ppu_timing (
        .clk           (clk),
        .reset         (reset),
        .display_en    (cfg.lcdc.display_en),
        .ly_reset      (ly_reset),
        .drawing       (drawing),
        .line          (line),
        .mode          (mode),
        .intreq_vblank (intreq_vblank)
    );

    bg_fetcher i_bg_fetcher (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .line        (line),
        .line_abort  (line_abort),
        .row_taken   (row_taken),
        .vram_data_r (vram_data_r),
        .fetch_addr  (fetch_addr),
        .fetch_busy  (fetch_busy),
        .row         (row),
        .row_valid   (row_valid)
    );

    pixel_fifo #(
        .VISIBLE_W (VISIBLE_W)
    ) i_pixel_fifo (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .line       (line),
        .row        (row),
        .row_valid  (row_valid),
        .row_taken  (row_taken),
        .line_abort (line_abort),
        .drawing    (drawing),
        .lcd_write  (lcd_write),
        .lcd_col    (lcd_col),
        .lcd_x      (lcd_x),
        .lcd_y      (lcd_y),
        .lcd_hblank (lcd_hblank),
        .lcd_vblank (lcd_vblank)
    );

endmodule

`default_nettype wire

/* verif/ppu_tb_vram.sv */
`default_nettype none
`timescale 1ns/1ns

module ppu_tb_vram (
    input  wire logic               clk,
    input  wire ppu_bus_pkg::addr_t addr,
    input  wire ppu_bus_pkg::byte_t wdata,
    input  wire logic               we,
    output ppu_bus_pkg::byte_t      rdata
);
    import ppu_bus_pkg::*;

    // Back-door array, also read by the reference model
    byte_t mem [0:8191];
    logic  in_range;

    assign in_range = addr >= 16'h8000 && addr < 16'ha000;

    initial begin
        rdata = 8'hff;
        for (int a = 0; a < 8192; a++)
            mem[a] = byte_t'(a ^ (a >> 8));
    end

    // One cycle of read latency
    always @(posedge clk) begin
        if (we && in_range)
            mem[addr[12:0]] <= wdata;
        rdata <= in_range ? mem[addr[12:0]] : 8'hff;
    end

    function automatic byte_t peek(input int a);
        return mem[a - 32'h8000];
    endfunction

endmodule

`default_nettype wire

/* verif/ppu_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module ppu_tb;
    import ppu_bus_pkg::*;
    import ppu_video_pkg::*;

    localparam int VISIBLE_W = 16;
    localparam int VISIBLE_H = 4;
    localparam int LINE_DOTS = 64;
    localparam int FRAME_LINES = 6;
    localparam int SEARCH_DOTS = 8;
    localparam int FRAME_CYCLES = LINE_DOTS * FRAME_LINES;
    localparam int TIMEOUT_CYCLES = 24 * FRAME_CYCLES + 40000;

    logic clk;
    logic reset;
    addr_t mem_addr;
    byte_t mem_data_write;
    logic mem_do_write;
    byte_t mem_data_read;
    logic mem_data_active;
    addr_t vram_addr;
    byte_t vram_data_w;
    byte_t vram_data_r;
    logic vram_do_write;
    logic intreq_vblank;
    logic lcd_hblank;
    logic lcd_vblank;
    logic lcd_write;
    logic [1:0] lcd_col;
    pos_t lcd_x;
    pos_t lcd_y;

    int seed = 32'h2900;
    int errors = 0;
    int total_writes = 0;
    int vbl_count = 0;
    logic disp_on = 1'b0;   // Monitors only check while the display runs
    byte_t cur_scx, cur_scy, cur_bgp;
    logic cur_map, cur_data;

    ppu_top #(
        .VISIBLE_W (VISIBLE_W), .VISIBLE_H (VISIBLE_H), .LINE_DOTS (LINE_DOTS),
        .FRAME_LINES (FRAME_LINES), .SEARCH_DOTS (SEARCH_DOTS)
    ) i_ppu_top (
        .clk (clk), .reset (reset), .mem_addr (mem_addr),
        .mem_data_write (mem_data_write), .mem_do_write (mem_do_write),
        .mem_data_read (mem_data_read), .mem_data_active (mem_data_active),
        .vram_addr (vram_addr), .vram_data_w (vram_data_w), .vram_data_r (vram_data_r),
        .vram_do_write (vram_do_write), .intreq_vblank (intreq_vblank),
        .lcd_hblank (lcd_hblank), .lcd_vblank (lcd_vblank), .lcd_write (lcd_write),
        .lcd_col (lcd_col), .lcd_x (lcd_x), .lcd_y (lcd_y)
    );

    ppu_tb_vram i_vram (
        .clk (clk), .addr (vram_addr), .wdata (vram_data_w),
        .we (vram_do_write), .rdata (vram_data_r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_eq(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic cpu_write(input addr_t a, input byte_t d);
        @(posedge clk);
        mem_addr <= a;
        mem_data_write <= d;
        mem_do_write <= 1'b1;
        @(posedge clk);
        check_eq("active during write", 0, mem_data_active);
        mem_do_write <= 1'b0;
    endtask

    // Two edges cover the VRAM read latency
    task automatic cpu_read(input addr_t a, output byte_t d, output logic active);
        @(posedge clk);
        mem_addr <= a;
        mem_do_write <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        d = mem_data_read;
        active = mem_data_active;
    endtask

    task automatic read_expect(input string name, input addr_t a, input byte_t exp,
                               input logic exp_active);
        byte_t d;
        logic act;
        cpu_read(a, d, act);
        check_eq(name, exp, d);
        check_eq({name, " active"}, exp_active, act);
    endtask

    task automatic wait_vblank_irq(input int n);
        repeat (n) begin
            @(posedge clk);
            while (!intreq_vblank)
                @(posedge clk);
        end
    endtask

    function automatic logic [1:0] expected_colour(input pos_t px, input pos_t py);
        byte_t bx, by, idx, lo, hi;
        int maddr, taddr, toff;
        logic [1:0] c;
        bx = px + cur_scx;
        by = py + cur_scy;
        maddr = (cur_map ? 32'h9c00 : 32'h9800) + (by >> 3) * 32 + (bx >> 3);
        idx = i_vram.peek(maddr);
        toff = cur_data ? int'(idx) : int'($signed(idx));
        taddr = (cur_data ? 32'h8000 : 32'h9000) + toff * 16 + (by % 8) * 2;
        lo = i_vram.peek(taddr);
        hi = i_vram.peek(taddr + 1);
        c = {hi[7 - bx[2:0]], lo[7 - bx[2:0]]};
        return cur_bgp[2 * c +: 2];
    endfunction

    // Line, pixel and frame monitor
    int wcount = 0;
    int since_vbl = 0;
    logic vbl_seen = 1'b0;
    logic prev_valid = 1'b0;
    pos_t prev_y, cur_y;
    always @(posedge clk) begin
        since_vbl++;
        assert (reset || !(lcd_write && lcd_vblank)) else begin
            errors++;
            $display("Pixel written during vblank at line %0d", lcd_y);
        end
        if (!disp_on || reset) begin
            wcount = 0;
            prev_valid = 1'b0;
            vbl_seen = 1'b0;
        end else begin
            if (intreq_vblank) begin
                vbl_count++;
                check_eq("vblank level", 1, lcd_vblank);
                if (vbl_seen)
                    check_eq("frame period", FRAME_CYCLES, since_vbl);
                vbl_seen = 1'b1;
                since_vbl = 0;
            end
            if (lcd_write) begin
                total_writes++;
                if (wcount == 0) begin
                    cur_y = lcd_y;
                    assert (cur_y < VISIBLE_H) else begin
                        errors++;
                        $display("Pixel written on line %0d outside the visible area", cur_y);
                    end
                    if (prev_valid)
                        check_eq("line order", (prev_y + 1) % VISIBLE_H, cur_y);
                end
                check_eq("lcd_x", wcount, lcd_x);
                check_eq("lcd_y", cur_y, lcd_y);
                check_eq("pixel", expected_colour(lcd_x, lcd_y), lcd_col);
                wcount++;
            end
            if (lcd_hblank) begin
                check_eq("writes per line", VISIBLE_W, wcount);
                prev_y = cur_y;
                prev_valid = 1'b1;
                wcount = 0;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("Watchdog expired before the tests finished, errors so far: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        byte_t d, ly0, ly1;
        logic act;
        int changes;
        reset = 1'b1;
        mem_addr = '0;
        mem_data_write = '0;
        mem_do_write = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Register readback and address decode
        repeat (8) begin
            d = $random(seed);
            cpu_write(REG_SCX, d);
            read_expect("SCX", REG_SCX, d, 1'b1);
            d = $random(seed);
            cpu_write(REG_SCY, d);
            read_expect("SCY", REG_SCY, d, 1'b1);
            d = $random(seed);
            cpu_write(REG_LYC, d);
            read_expect("LYC", REG_LYC, d, 1'b1);
            d = $random(seed);
            cpu_write(REG_BGP, d);
            read_expect("BGP", REG_BGP, d, 1'b1);
            d = $random(seed) & 8'h7f;
            cpu_write(REG_LCDC, d);
            read_expect("LCDC", REG_LCDC, d, 1'b1);
        end
        read_expect("unused IO", 16'hff4a, 8'hff, 1'b1);
        read_expect("above IO", 16'hff4c, 8'hff, 1'b0);
        read_expect("below VRAM", 16'h7fff, 8'hff, 1'b0);
        cpu_write(16'h8123, 8'h5a);
        read_expect("VRAM passthrough", 16'h8123, 8'h5a, 1'b1);

        // Frame timing through LY reads
        cur_map = 1'b0;
        cur_data = 1'b1;
        cur_scx = $random(seed);
        cur_scy = $random(seed);
        cur_bgp = $random(seed);
        cpu_write(REG_SCX, cur_scx);
        cpu_write(REG_SCY, cur_scy);
        cpu_write(REG_BGP, cur_bgp);
        cpu_write(REG_LCDC, 8'h91);
        disp_on <= 1'b1;
        cpu_read(REG_LY, ly0, act);
        changes = 0;
        repeat (FRAME_CYCLES * 2 / 3) begin
            cpu_read(REG_LY, ly1, act);
            if (ly1 != ly0) begin
                changes++;
                check_eq("LY step", (ly0 + 1) % FRAME_LINES, ly1);
            end
            ly0 = ly1;
        end
        assert (changes >= FRAME_LINES) else begin
            errors++;
            $display("LY changed only %0d times over two frames", changes);
        end

        // Pixels for every map and data select
        for (int sel = 0; sel < 4; sel++) begin
            disp_on <= 1'b0;
            cpu_write(REG_LCDC, 8'h00);
            for (int a = 0; a < 8192; a++)
                i_vram.mem[a] = $random(seed);
            cur_map = sel[0];
            cur_data = sel[1];
            cur_scx = $random(seed);
            cur_scy = $random(seed);
            cur_bgp = $random(seed);
            cpu_write(REG_SCX, cur_scx);
            cpu_write(REG_SCY, cur_scy);
            cpu_write(REG_BGP, cur_bgp);
            cpu_write(REG_LCDC, {1'b1, 2'b00, cur_data, cur_map, 3'b001});
            disp_on <= 1'b1;
            wait_vblank_irq(3);
        end

        // Freeze and LY reset
        disp_on <= 1'b0;
        cpu_write(REG_LCDC, 8'h11);
        cpu_read(REG_LY, ly0, act);
        repeat (LINE_DOTS) begin
            cpu_read(REG_LY, ly1, act);
            check_eq("frozen LY", ly0, ly1);
        end
        cpu_write(REG_LY, 8'h77);
        read_expect("LY after reset", REG_LY, 8'h00, 1'b1);

        assert (total_writes > 0 && vbl_count > 0) else begin
            errors++;
            $display("No pixels or vblank interrupts were seen");
        end
        $display("Errors: %0d, pixels checked: %0d, vblank interrupts: %0d",
                 errors, total_writes, vbl_count);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ppu.f */
common/ppu_bus_pkg.sv
common/ppu_video_pkg.sv
verilog/ppu_regs.sv
verilog/ppu_timing.sv
render/bg_fetcher.sv
render/pixel_fifo.sv
verilog/ppu_top.sv
verif/ppu_tb_vram.sv
verif/ppu_tb.sv

/* Bender.yml */
package:
  name: ppu

sources:
  - common/ppu_bus_pkg.sv
  - common/ppu_video_pkg.sv
  - verilog/ppu_regs.sv
  - verilog/ppu_timing.sv
  - render/bg_fetcher.sv
  - render/pixel_fifo.sv
  - verilog/ppu_top.sv
  - target: test
    files:
      - verif/ppu_tb_vram.sv
      - verif/ppu_tb.sv
